//--- hw/i3c_tgtrst_params.svh
`ifndef I3C_TGTRST_PARAMS_SVH
`define I3C_TGTRST_PARAMS_SVH

// flops per line in the input synchronizer
`define I3C_SYNC_STAGES 2

// sda transitions during scl low that make up the reset pattern
`define I3C_RST_TRANSITIONS 14

// clk_i cycles sda must stay put, scl high, before start or stop counts
`define I3C_HOLD_CYCLES 4

// width of the saturating reset event count
`define I3C_EVT_CNT_W 8

`endif

//--- hw/controller_pkg.sv
`include "i3c_tgtrst_params.svh"

package controller_pkg;

  // synchronized line levels and edges, one sample per clk_i
  typedef struct packed {
    logic scl_low;
    logic scl_high;
    logic scl_negedge;
    logic sda_posedge;
    logic sda_negedge;
  } bus_lines_t;

  // qualified bus conditions, single-cycle strobes
  typedef struct packed {
    logic start;
    logic stop;
  } bus_cond_t;

  typedef struct packed {
    logic                      evt_pulse;  // one cycle per detected reset
    logic                      flag;       // sticky until clear
    logic [`I3C_EVT_CNT_W-1:0] count;      // saturates at all ones
  } reset_status_t;

  typedef enum logic [1:0] {
    AwaitPattern  = 2'h0,
    AwaitSr       = 2'h1,
    AwaitP        = 2'h2,
    ResetDetected = 2'h3
  } target_reset_detector_state_e;

endpackage

//--- hw/bus_line_sampler.sv
`include "i3c_tgtrst_params.svh"

module bus_line_sampler
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       sda_i,
  output bus_lines_t lines_o
);

  localparam int unsigned SyncStages = `I3C_SYNC_STAGES;

  // idle bus, both lines high and no edges
  localparam bus_lines_t LinesIdle = '{
    scl_low:     1'b0,
    scl_high:    1'b1,
    scl_negedge: 1'b0,
    sda_posedge: 1'b0,
    sda_negedge: 1'b0
  };

  // bit 1 carries scl, bit 0 carries sda
  logic [SyncStages-1:0][1:0] sync_q;
  logic [1:0]                 hist_q;
  logic [1:0]                 line_now;
  bus_lines_t                 lines_d;
  bus_lines_t                 lines_q;

  assign line_now = sync_q[SyncStages-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= '1;  // reset to idle high so no false edge
      hist_q <= 2'b11;
    end else begin
      sync_q[0] <= {scl_i, sda_i};
      for (int i = 1; i < SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      hist_q <= line_now;
    end
  end

  always_comb begin
    lines_d.scl_low     = ~line_now[1];
    lines_d.scl_high    = line_now[1];
    lines_d.scl_negedge = hist_q[1] & ~line_now[1];
    lines_d.sda_posedge = ~hist_q[0] & line_now[0];
    lines_d.sda_negedge = hist_q[0] & ~line_now[0];
  end

  // output stage keeps levels and edges aligned
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lines_q <= LinesIdle;
    end else begin
      lines_q <= lines_d;
    end
  end

  assign lines_o = lines_q;

endmodule

//--- hw/bus_condition_detector.sv
`include "i3c_tgtrst_params.svh"

module bus_condition_detector
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  bus_lines_t lines_i,
  output bus_cond_t  cond_o
);

  localparam int unsigned HoldCycles = `I3C_HOLD_CYCLES;
  localparam int unsigned HoldW      = $clog2(HoldCycles + 1);

  logic [HoldW-1:0] hold_cnt_q;
  logic [HoldW-1:0] hold_cnt_d;
  logic             armed_q;
  logic             armed_d;
  logic             rising_q;  // direction of the edge being qualified
  logic             rising_d;

  logic sda_edge;
  logic new_attempt;
  logic abort;
  logic hold_done;

  assign sda_edge    = lines_i.sda_posedge | lines_i.sda_negedge;
  assign new_attempt = sda_edge & lines_i.scl_high;

  // scl dropping or sda moving again ends the current attempt
  assign abort     = lines_i.scl_negedge | sda_edge;
  assign hold_done = armed_q & ~abort & (hold_cnt_q == HoldW'(HoldCycles));

  always_comb begin
    armed_d    = armed_q;
    hold_cnt_d = hold_cnt_q;
    rising_d   = rising_q;
    if (new_attempt) begin
      armed_d    = 1'b1;  // a fresh edge restarts, even mid attempt
      hold_cnt_d = HoldW'(1);
      rising_d   = lines_i.sda_posedge;
    end else if (abort || hold_done) begin
      armed_d    = 1'b0;
      hold_cnt_d = '0;
    end else if (armed_q) begin
      hold_cnt_d = hold_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q    <= 1'b0;
      hold_cnt_q <= '0;
      rising_q   <= 1'b0;
    end else begin
      armed_q    <= armed_d;
      hold_cnt_q <= hold_cnt_d;
      rising_q   <= rising_d;
    end
  end

  // falling sda with scl high is start, rising is stop
  assign cond_o.start = hold_done & ~rising_q;
  assign cond_o.stop  = hold_done & rising_q;

endmodule

//--- hw/target_reset_detector.sv
`include "i3c_tgtrst_params.svh"

module target_reset_detector
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       enable_i,
  input  bus_lines_t lines_i,
  input  bus_cond_t  cond_i,
  output logic       target_reset_detect_o
);

  localparam logic [3:0] RstTransitions = 4'(`I3C_RST_TRANSITIONS);

  logic       count_en;
  logic [3:0] sda_trans_cnt_q;
  logic [3:0] sda_trans_cnt_d;

  target_reset_detector_state_e state_q, state_d;

  // the first rising edge is the release after a prior start, so skip it
  always_comb begin
    if ((state_q == AwaitPattern) && (sda_trans_cnt_q < RstTransitions)) begin
      count_en = lines_i.sda_negedge | (lines_i.sda_posedge & (sda_trans_cnt_q != 4'h0));
    end else begin
      count_en = 1'b0;
    end
  end

  always_comb begin
    if (!enable_i || lines_i.scl_high) begin
      sda_trans_cnt_d = 4'h0;
    end else if (count_en) begin
      sda_trans_cnt_d = sda_trans_cnt_q + 4'h1;
    end else begin
      sda_trans_cnt_d = sda_trans_cnt_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sda_trans_cnt_q <= 4'h0;
    end else begin
      sda_trans_cnt_q <= sda_trans_cnt_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      AwaitPattern: begin
        if (sda_trans_cnt_q == RstTransitions) begin
          state_d = AwaitSr;
        end
      end
      AwaitSr: begin
        // a rising sda here means the start did not meet its hold time
        if (lines_i.scl_low || lines_i.sda_posedge) begin
          state_d = AwaitPattern;
        end else if (cond_i.start) begin
          state_d = AwaitP;
        end
      end
      AwaitP: begin
        // likewise a falling sda means the stop was cut short
        if (lines_i.scl_low || lines_i.sda_negedge) begin
          state_d = AwaitPattern;
        end else if (cond_i.stop) begin
          state_d = ResetDetected;
        end
      end
      ResetDetected: begin
        state_d = AwaitPattern;
      end
      default: begin
        state_d = AwaitPattern;
      end
    endcase
    if (!enable_i) begin
      state_d = AwaitPattern;  // disabled detector stays parked
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= AwaitPattern;
    end else begin
      state_q <= state_d;
    end
  end

  assign target_reset_detect_o = (state_d == ResetDetected);  // same cycle as stop

endmodule

//--- hw/reset_event_reporter.sv
`include "i3c_tgtrst_params.svh"

module reset_event_reporter
  import controller_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          detect_i,
  input  logic          clear_i,
  output reset_status_t status_o
);

  localparam int unsigned CntW = `I3C_EVT_CNT_W;

  logic            evt_q;
  logic            flag_q;
  logic [CntW-1:0] count_q;
  logic [CntW-1:0] count_d;

  always_comb begin
    count_d = count_q;
    if (detect_i) begin
      if (clear_i) begin
        count_d = CntW'(1);  // detect wins over a clear in the same cycle
      end else if (count_q != '1) begin
        count_d = count_q + 1'b1;
      end
    end else if (clear_i) begin
      count_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_q   <= 1'b0;
      flag_q  <= 1'b0;
      count_q <= '0;
    end else begin
      evt_q   <= detect_i;
      count_q <= count_d;
      if (detect_i) begin
        flag_q <= 1'b1;
      end else if (clear_i) begin
        flag_q <= 1'b0;
      end
    end
  end

  assign status_o.evt_pulse = evt_q;
  assign status_o.flag      = flag_q;
  assign status_o.count     = count_q;

endmodule

//--- hw/i3c_tgtrst_top.sv
module i3c_tgtrst_top
  import controller_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          scl_i,
  input  logic          sda_i,
  input  logic          enable_i,
  input  logic          clear_i,
  output reset_status_t status_o
);

  bus_lines_t lines;
  bus_cond_t  cond;
  logic       target_reset_detect;

  bus_line_sampler u_sampler (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .lines_o (lines)
  );

  bus_condition_detector u_cond_det (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .lines_i (lines),
    .cond_o  (cond)
  );

  target_reset_detector u_rst_det (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .enable_i              (enable_i),
    .lines_i               (lines),
    .cond_i                (cond),
    .target_reset_detect_o (target_reset_detect)
  );

  reset_event_reporter u_reporter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .detect_i (target_reset_detect),
    .clear_i  (clear_i),
    .status_o (status_o)
  );

endmodule

//--- sim/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    rst_no = 1'b1;  // released just after the fourth edge
  end

endmodule

//--- sim/i3c_tgtrst_tb.sv
`include "i3c_tgtrst_params.svh"

module i3c_tgtrst_tb
  import controller_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          Phase     = 16;  // longer than sync plus hold
  localparam int          MaxCycles = 40 * 400 + 1000;
  localparam int          CntW      = `I3C_EVT_CNT_W;
  localparam logic [31:0] Seed      = 32'ha69c320c;

  logic          clk, rst_n, scl, sda, enable, clear;
  reset_status_t status;

  logic [31:0]     rnd;
  int              toggles;
  bit              sr_ok, p_ok, drop;
  logic            exp_flag = 1'b0;
  logic [CntW-1:0] exp_count = '0;
  int              exp_pulses = 0;
  int              pulses_seen = 0;
  int              windows_done = 0;
  int              windows_checked = 0;
  int              pulse_errs = 0;
  int              flag_errs = 0;
  int              count_errs = 0;
  int              cycle_cnt = 0;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  i3c_tgtrst_top dut0 (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .scl_i    (scl),
    .sda_i    (sda),
    .enable_i (enable),
    .clear_i  (clear),
    .status_o (status)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // a reset is seen only for a full pattern followed by a clean Sr and P
  function automatic bit expect_event(input bit en, input int n, input bit sr_hold,
                                      input bit p_hold, input bit scl_low_mid);
    return en && (n >= `I3C_RST_TRANSITIONS) && sr_hold && p_hold && !scl_low_mid;
  endfunction

  function automatic logic [CntW-1:0] next_count(input logic [CntW-1:0] cnt, input bit hit);
    if (hit && (cnt != {CntW{1'b1}})) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  task automatic hold_lines(input logic scl_v, input logic sda_v, input int cycles);
    scl = scl_v;
    sda = sda_v;
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic close_window(input int pulses);
    exp_pulses = pulses;
    windows_done++;
    wait (windows_checked == windows_done);
    @(posedge clk);
    #1;
  endtask

  task automatic run_pattern(input int n, input bit sr_hold, input bit p_hold,
                             input bit scl_low_mid);
    bit   hit;
    logic sda_lvl;
    hit     = expect_event(enable, n, sr_hold, p_hold, scl_low_mid);
    sda_lvl = 1'b1;
    hold_lines(1'b1, 1'b1, Phase);  // idle bus
    hold_lines(1'b0, 1'b1, Phase);
    for (int i = 0; i < n; i++) begin
      sda_lvl = ~sda_lvl;
      hold_lines(1'b0, sda_lvl, Phase);
    end
    hold_lines(1'b1, sda_lvl, Phase);
    if (!sda_lvl) begin
      hold_lines(1'b1, 1'b1, Phase);  // odd count leaves sda low
    end
    if (sr_hold) begin
      hold_lines(1'b1, 1'b0, Phase);
    end else begin
      hold_lines(1'b1, 1'b0, 2);
      hold_lines(1'b1, 1'b1, Phase - 2);
    end
    sda_lvl = !sr_hold;
    if (scl_low_mid) begin
      hold_lines(1'b0, sda_lvl, Phase);
      hold_lines(1'b1, sda_lvl, Phase);
    end
    if (sda_lvl) begin
      hold_lines(1'b1, 1'b0, Phase);  // sda low again ahead of the P
    end
    if (p_hold) begin
      hold_lines(1'b1, 1'b1, Phase);
    end else begin
      hold_lines(1'b1, 1'b1, 2);
      hold_lines(1'b1, 1'b0, Phase - 2);
      hold_lines(1'b1, 1'b1, Phase);
    end
    hold_lines(1'b1, 1'b1, Phase);  // tail where the pulse lands
    if (hit) begin
      exp_flag = 1'b1;
    end
    exp_count = next_count(exp_count, hit);
    close_window(hit ? 1 : 0);
  endtask

  task automatic pulse_clear();
    clear = 1'b1;
    @(posedge clk);
    #1;
    clear     = 1'b0;
    exp_flag  = 1'b0;
    exp_count = '0;
    close_window(0);
  endtask

  // sample away from the rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (status.evt_pulse) begin
        pulses_seen++;
      end
      if (windows_checked != windows_done) begin
        if (pulses_seen != exp_pulses) begin
          $display("FAILED evt_pulse count window %0d: expected 0x%0h got 0x%0h",
                   windows_done, exp_pulses, pulses_seen);
          pulse_errs++;
        end
        if (status.flag !== exp_flag) begin
          $display("FAILED flag window %0d: expected 0x%0h got 0x%0h",
                   windows_done, exp_flag, status.flag);
          flag_errs++;
        end
        if (status.count !== exp_count) begin
          $display("FAILED count window %0d: expected 0x%0h got 0x%0h",
                   windows_done, exp_count, status.count);
          count_errs++;
        end
        pulses_seen = 0;
        windows_checked++;
      end
    end
  end

  initial begin
    while (cycle_cnt < MaxCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run still busy after %0d clock cycles", MaxCycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    scl    = 1'b1;
    sda    = 1'b1;
    enable = 1'b1;
    clear  = 1'b0;
    rnd    = Seed;
    @(posedge rst_n);
    @(posedge clk);
    #1;
    close_window(0);  // reset values
    run_pattern(14, 1'b1, 1'b1, 1'b0);
    run_pattern(14, 1'b1, 1'b1, 1'b0);
    run_pattern(13, 1'b1, 1'b1, 1'b0);
    run_pattern(12, 1'b1, 1'b1, 1'b0);
    run_pattern(14, 1'b0, 1'b1, 1'b0);
    run_pattern(14, 1'b1, 1'b0, 1'b0);
    run_pattern(14, 1'b1, 1'b1, 1'b1);
    enable = 1'b0;
    run_pattern(14, 1'b1, 1'b1, 1'b0);
    enable = 1'b1;
    pulse_clear();
    run_pattern(14, 1'b1, 1'b1, 1'b0);
    for (int k = 0; k < 30; k++) begin
      rnd     = lcg_next(rnd);
      toggles = 10 + int'(rnd[31:16] % 16'd5);
      rnd     = lcg_next(rnd);
      sr_ok   = (rnd[31:30] != 2'b00);
      rnd     = lcg_next(rnd);
      p_ok    = (rnd[31:30] != 2'b00);
      rnd     = lcg_next(rnd);
      drop    = (rnd[31:29] == 3'b000);
      run_pattern(toggles, sr_ok, p_ok, drop);
    end
    $display("errors: %0d total, pulse %0d, flag %0d, count %0d",
             pulse_errs + flag_errs + count_errs, pulse_errs, flag_errs, count_errs);
    if ((pulse_errs + flag_errs + count_errs) == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- i3c_tgtrst.f
+incdir+hw
hw/controller_pkg.sv
hw/bus_line_sampler.sv
hw/bus_condition_detector.sv
hw/target_reset_detector.sv
hw/reset_event_reporter.sv
hw/i3c_tgtrst_top.sv
sim/tb_clk_gen.sv
sim/i3c_tgtrst_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps \
  -f i3c_tgtrst.f --top-module i3c_tgtrst_tb -o i3c_tgtrst_sim &&
./obj_dir/i3c_tgtrst_sim | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
